// File: rtl/cache_bus_defs.svh
`ifndef CACHE_BUS_DEFS_SVH
`define CACHE_BUS_DEFS_SVH

// byte address
`define ADDR_W 32

// one memory word per beat on the memory port
`define DATA_W 32

// byte strobes per word
`define STRB_W 4

// beats per cache block
`define WORDS_PER_BLOCK 4

// full cache block
`define BLOCK_W 128

`endif

// File: rtl/cache_bus_pkg.sv
`default_nettype none

package cache_bus_pkg;

    // instruction cache request code held as a level
    typedef enum logic [1:0] {
        IREQ_NONE,
        IREQ_BLOCK,
        IREQ_WORD
    } icache_req_t;

    // data cache request code held as a level
    typedef enum logic [2:0] {
        DREQ_NONE,
        DREQ_LOAD_BLOCK,
        DREQ_LOAD_WORD,
        DREQ_STORE_WORD,
        DREQ_WB_LOAD_BLOCK
    } dcache_req_t;

    // operation handed to the transfer engine
    typedef enum logic [2:0] {
        XFER_NONE,
        XFER_LOAD_BLOCK,
        XFER_LOAD_WORD,
        XFER_STORE_BLOCK,
        XFER_STORE_WORD
    } xfer_op_t;

    typedef enum logic [1:0] {
        RESP_NONE,
        RESP_ICACHE,
        RESP_DCACHE
    } resp_t;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_ISSUE,
        SEQ_WAIT_READY,
        SEQ_WAIT_FINISH,
        SEQ_WB_REFILL,
        SEQ_DONE
    } seq_state_t;

    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_BEAT,
        ENG_DONE
    } eng_state_t;

endpackage

`default_nettype wire

// File: rtl/xfer_if.sv
`timescale 1ns/100ps
`default_nettype none
`include "cache_bus_defs.svh"

interface xfer_if
    import cache_bus_pkg::*;
();

    // one-cycle operation pulse with its address and write data
    xfer_op_t              op;
    logic [`ADDR_W-1:0]    addr;
    logic [`BLOCK_W-1:0]   wblock;
    logic [`DATA_W-1:0]    wword;
    logic [`STRB_W-1:0]    wstrb;

    // engine status and read data
    logic                  ready;
    logic                  finish;
    logic [`BLOCK_W-1:0]   rblock;
    logic [`DATA_W-1:0]    rword;

    modport seq (
        output op, addr, wblock, wword, wstrb,
        input  ready, finish, rblock, rword
    );

    modport eng (
        input  op, addr, wblock, wword, wstrb,
        output ready, finish, rblock, rword
    );

endinterface

`default_nettype wire

// File: rtl/cache_req_sequencer.sv
`timescale 1ns/100ps
`default_nettype none
`include "cache_bus_defs.svh"

module cache_req_sequencer
    import cache_bus_pkg::*;
(
    input  logic                clk,
    input  logic                rstn,

    input  icache_req_t         icache_req,
    input  logic [`ADDR_W-1:0]  icache_addr,

    input  dcache_req_t         dcache_req,
    input  logic [`ADDR_W-1:0]  dcache_addr,
    input  logic [`BLOCK_W-1:0] dcache_wblock,
    input  logic [`DATA_W-1:0]  dcache_wword,
    input  logic [`STRB_W-1:0]  dcache_wstrb,

    output resp_t               response,
    output logic [`BLOCK_W-1:0] rblock_to_cache,
    output logic [`DATA_W-1:0]  rword_to_cache,

    xfer_if.seq                 xfer
);

    seq_state_t state;
    seq_state_t state_nxt;

    // requester that owns the current transaction
    resp_t      owner;
    // set while a write-back still owes its refill
    logic       refill_pending;

    xfer_op_t   pick_op;
    logic       pick_d;
    xfer_op_t   issue_op;

    // data cache wins over the instruction cache
    always_comb begin
        pick_op = XFER_NONE;
        pick_d  = 1'b1;
        case (dcache_req)
            DREQ_LOAD_BLOCK:    pick_op = XFER_LOAD_BLOCK;
            DREQ_LOAD_WORD:     pick_op = XFER_LOAD_WORD;
            DREQ_STORE_WORD:    pick_op = XFER_STORE_WORD;
            // victim goes out first
            DREQ_WB_LOAD_BLOCK: pick_op = XFER_STORE_BLOCK;
            default: begin
                pick_d = 1'b0;
                case (icache_req)
                    IREQ_BLOCK: pick_op = XFER_LOAD_BLOCK;
                    IREQ_WORD:  pick_op = XFER_LOAD_WORD;
                    default:    pick_op = XFER_NONE;
                endcase
            end
        endcase
    end

    assign issue_op = (state == SEQ_WB_REFILL) ? XFER_LOAD_BLOCK : pick_op;

    always_comb begin
        state_nxt = state;
        case (state)
            SEQ_IDLE: begin
                if (pick_op != XFER_NONE) begin
                    state_nxt = SEQ_ISSUE;
                end
            end
            SEQ_ISSUE: begin
                state_nxt = SEQ_WAIT_READY;
            end
            SEQ_WAIT_READY: begin
                if (xfer.ready) begin
                    state_nxt = SEQ_WAIT_FINISH;
                end
            end
            SEQ_WAIT_FINISH: begin
                if (xfer.finish) begin
                    state_nxt = refill_pending ? SEQ_WB_REFILL : SEQ_DONE;
                end
            end
            SEQ_WB_REFILL: begin
                state_nxt = SEQ_ISSUE;
            end
            SEQ_DONE: begin
                state_nxt = SEQ_IDLE;
            end
            default: begin
                state_nxt = SEQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state          <= SEQ_IDLE;
            xfer.op        <= XFER_NONE;
            response       <= RESP_NONE;
            owner          <= RESP_NONE;
            refill_pending <= 1'b0;
        end else begin
            state    <= state_nxt;
            // op and response both follow the next state
            xfer.op  <= (state_nxt == SEQ_ISSUE) ? issue_op : XFER_NONE;
            response <= (state_nxt == SEQ_DONE) ? owner : RESP_NONE;
            if (state == SEQ_IDLE && pick_op != XFER_NONE) begin
                owner          <= pick_d ? RESP_DCACHE : RESP_ICACHE;
                refill_pending <= (pick_op == XFER_STORE_BLOCK);
            end else if (state == SEQ_WB_REFILL) begin
                refill_pending <= 1'b0;
            end
        end
    end

    // refill reuses the captured address
    always_ff @(posedge clk) begin
        if (state == SEQ_IDLE && pick_op != XFER_NONE) begin
            xfer.addr   <= pick_d ? dcache_addr : icache_addr;
            xfer.wblock <= dcache_wblock;
            xfer.wword  <= dcache_wword;
            xfer.wstrb  <= dcache_wstrb;
        end
    end

    // engine holds its read data past finish
    assign rblock_to_cache = xfer.rblock;
    assign rword_to_cache  = xfer.rword;

endmodule

`default_nettype wire

// File: rtl/mem_xfer_engine.sv
`timescale 1ns/100ps
`default_nettype none
`include "cache_bus_defs.svh"

module mem_xfer_engine
    import cache_bus_pkg::*;
(
    input  logic                clk,
    input  logic                rstn,

    xfer_if.eng                 xfer,

    output logic                mem_valid,
    output logic                mem_we,
    output logic [`ADDR_W-1:0]  mem_addr,
    output logic [`DATA_W-1:0]  mem_wdata,
    output logic [`STRB_W-1:0]  mem_wstrb,
    input  logic                mem_ready,
    input  logic [`DATA_W-1:0]  mem_rdata
);

    localparam int BEAT_W  = $clog2(`WORDS_PER_BLOCK);
    localparam int WORD_OFF = $clog2(`STRB_W);
    localparam int BLK_OFF = $clog2(`WORDS_PER_BLOCK * `STRB_W);

    eng_state_t          state;
    xfer_op_t            cur_op;
    logic [BEAT_W-1:0]   beat;
    logic [BEAT_W-1:0]   beat_nxt;
    logic [`BLOCK_W-1:0] wblock_q;

    logic                is_word;
    logic                last_beat;
    logic                op_block;
    logic                op_store;
    logic [`ADDR_W-1:0]  word_addr;
    logic [`ADDR_W-1:0]  blk_addr;

    assign op_block = (xfer.op == XFER_LOAD_BLOCK) || (xfer.op == XFER_STORE_BLOCK);
    assign op_store = (xfer.op == XFER_STORE_BLOCK) || (xfer.op == XFER_STORE_WORD);

    assign word_addr = {xfer.addr[`ADDR_W-1:WORD_OFF], {WORD_OFF{1'b0}}};
    assign blk_addr  = {xfer.addr[`ADDR_W-1:BLK_OFF], {BLK_OFF{1'b0}}};

    assign is_word   = (cur_op == XFER_LOAD_WORD) || (cur_op == XFER_STORE_WORD);
    assign last_beat = is_word || (beat == BEAT_W'(`WORDS_PER_BLOCK - 1));
    assign beat_nxt  = beat + 1'b1;

    // finish is high for the single done cycle
    assign xfer.finish = (state == ENG_DONE);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state      <= ENG_IDLE;
            cur_op     <= XFER_NONE;
            beat       <= '0;
            mem_valid  <= 1'b0;
            xfer.ready <= 1'b0;
        end else begin
            xfer.ready <= 1'b0;
            case (state)
                ENG_IDLE: begin
                    if (xfer.op != XFER_NONE) begin
                        cur_op     <= xfer.op;
                        beat       <= '0;
                        mem_valid  <= 1'b1;
                        xfer.ready <= 1'b1;
                        state      <= ENG_BEAT;
                    end
                end
                ENG_BEAT: begin
                    if (mem_ready) begin
                        if (last_beat) begin
                            mem_valid <= 1'b0;
                            state     <= ENG_DONE;
                        end else begin
                            beat <= beat_nxt;
                        end
                    end
                end
                ENG_DONE: begin
                    state <= ENG_IDLE;
                end
                default: begin
                    state <= ENG_IDLE;
                end
            endcase
        end
    end

    // beat payload and gathered read data
    always_ff @(posedge clk) begin
        case (state)
            ENG_IDLE: begin
                if (xfer.op != XFER_NONE) begin
                    mem_we    <= op_store;
                    mem_addr  <= op_block ? blk_addr : word_addr;
                    mem_wdata <= op_block ? xfer.wblock[`DATA_W-1:0] : xfer.wword;
                    // block stores write whole words
                    mem_wstrb <= op_block ? {`STRB_W{1'b1}} : xfer.wstrb;
                    wblock_q  <= xfer.wblock;
                end
            end
            ENG_BEAT: begin
                if (mem_ready) begin
                    if (!mem_we) begin
                        if (is_word) begin
                            xfer.rword <= mem_rdata;
                        end else begin
                            xfer.rblock[beat*`DATA_W +: `DATA_W] <= mem_rdata;
                        end
                    end
                    if (!last_beat) begin
                        mem_addr  <= mem_addr + `ADDR_W'(`STRB_W);
                        mem_wdata <= wblock_q[beat_nxt*`DATA_W +: `DATA_W];
                    end
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/cache_bus_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "cache_bus_defs.svh"

module cache_bus_top
    import cache_bus_pkg::*;
(
    input  logic                clk,
    input  logic                rstn,

    // instruction cache
    input  icache_req_t         icache_req,
    input  logic [`ADDR_W-1:0]  icache_addr,

    // data cache
    input  dcache_req_t         dcache_req,
    input  logic [`ADDR_W-1:0]  dcache_addr,
    input  logic [`BLOCK_W-1:0] dcache_wblock,
    input  logic [`DATA_W-1:0]  dcache_wword,
    input  logic [`STRB_W-1:0]  dcache_wstrb,

    // shared response to both caches
    output resp_t               response,
    output logic [`BLOCK_W-1:0] rblock_to_cache,
    output logic [`DATA_W-1:0]  rword_to_cache,

    // memory port
    output logic                mem_valid,
    output logic                mem_we,
    output logic [`ADDR_W-1:0]  mem_addr,
    output logic [`DATA_W-1:0]  mem_wdata,
    output logic [`STRB_W-1:0]  mem_wstrb,
    input  logic                mem_ready,
    input  logic [`DATA_W-1:0]  mem_rdata
);

    xfer_if xfer_bus ();

    cache_req_sequencer u_seq (
        .clk             (clk),
        .rstn            (rstn),
        .icache_req      (icache_req),
        .icache_addr     (icache_addr),
        .dcache_req      (dcache_req),
        .dcache_addr     (dcache_addr),
        .dcache_wblock   (dcache_wblock),
        .dcache_wword    (dcache_wword),
        .dcache_wstrb    (dcache_wstrb),
        .response        (response),
        .rblock_to_cache (rblock_to_cache),
        .rword_to_cache  (rword_to_cache),
        .xfer            (xfer_bus.seq)
    );

    mem_xfer_engine u_eng (
        .clk       (clk),
        .rstn      (rstn),
        .xfer      (xfer_bus.eng),
        .mem_valid (mem_valid),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wstrb (mem_wstrb),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// File: tb/tb_cache_bus.sv
`timescale 1ns/100ps
`default_nettype none
`include "cache_bus_defs.svh"

module tb_cache_bus
    import cache_bus_pkg::*;
();

    localparam int MEM_WORDS   = 1024;
    localparam int CYCLE_LIMIT = 200 * 60;

    typedef struct {
        string               name;
        resp_t               resp;
        int                  kind;  // 0 no data, 1 word, 2 block
        logic [`BLOCK_W-1:0] blk;
        logic [`DATA_W-1:0]  word;
    } expect_t;

    logic                clk = 1'b0;
    logic                rstn;
    icache_req_t         icache_req;
    logic [`ADDR_W-1:0]  icache_addr;
    dcache_req_t         dcache_req;
    logic [`ADDR_W-1:0]  dcache_addr;
    logic [`BLOCK_W-1:0] dcache_wblock;
    logic [`DATA_W-1:0]  dcache_wword;
    logic [`STRB_W-1:0]  dcache_wstrb;
    resp_t               response;
    logic [`BLOCK_W-1:0] rblock_to_cache;
    logic [`DATA_W-1:0]  rword_to_cache;
    logic                mem_valid;
    logic                mem_we;
    logic [`ADDR_W-1:0]  mem_addr;
    logic [`DATA_W-1:0]  mem_wdata;
    logic [`STRB_W-1:0]  mem_wstrb;
    logic                mem_ready = 1'b0;
    logic [`DATA_W-1:0]  mem_rdata = '0;

    logic [`DATA_W-1:0]  mem [MEM_WORDS];
    logic [`DATA_W-1:0]  shadow [MEM_WORDS];
    expect_t             exp_q[$];
    // {we, addr} of every completed beat
    logic [`ADDR_W:0]    beat_log[$];
    int                  errors = 0;
    int                  checks = 0;
    int                  cycles = 0;

    cache_bus_top dut (.*);

    initial begin
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles with requests still outstanding", cycles);
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("Test failed");
            $finish;
        end
    end

    // memory model with random ready that writes on the completing beat
    always @(negedge clk) begin
        logic rdy;
        rdy = rstn && (($urandom % 4) != 0);
        mem_ready = rdy;
        mem_rdata = mem[mem_addr[11:2]];
        if (mem_valid && rdy) begin
            beat_log.push_back({mem_we, mem_addr});
            if (mem_we) begin
                for (int b = 0; b < `STRB_W; b++) begin
                    if (mem_wstrb[b]) begin
                        mem[mem_addr[11:2]][b*8 +: 8] = mem_wdata[b*8 +: 8];
                    end
                end
            end
        end
    end

    function automatic expect_t predict(input logic from_d, input icache_req_t ireq,
            input dcache_req_t dreq, input logic [`ADDR_W-1:0] addr,
            input logic [`BLOCK_W-1:0] wblock, input logic [`DATA_W-1:0] wword,
            input logic [`STRB_W-1:0] wstrb);
        expect_t    e;
        logic [9:0] w;
        logic [9:0] base;
        logic       load_word;
        logic       load_blk;
        w         = addr[11:2];
        base      = {addr[11:4], 2'b00};
        load_word = from_d ? (dreq == DREQ_LOAD_WORD) : (ireq == IREQ_WORD);
        load_blk  = from_d ? (dreq == DREQ_LOAD_BLOCK || dreq == DREQ_WB_LOAD_BLOCK)
                           : (ireq == IREQ_BLOCK);
        e.name = "";
        e.resp = from_d ? RESP_DCACHE : RESP_ICACHE;
        e.kind = 0;
        e.blk  = '0;
        e.word = '0;
        if (from_d && dreq == DREQ_STORE_WORD) begin
            for (int b = 0; b < `STRB_W; b++) begin
                if (wstrb[b]) begin
                    shadow[w][b*8 +: 8] = wword[b*8 +: 8];
                end
            end
        end
        // victim lands before the refill reads the block back
        if (from_d && dreq == DREQ_WB_LOAD_BLOCK) begin
            for (int k = 0; k < `WORDS_PER_BLOCK; k++) begin
                shadow[base + 10'(k)] = wblock[k*`DATA_W +: `DATA_W];
            end
        end
        if (load_word) begin
            e.kind = 1;
            e.word = shadow[w];
        end
        if (load_blk) begin
            e.kind = 2;
            for (int k = 0; k < `WORDS_PER_BLOCK; k++) begin
                e.blk[k*`DATA_W +: `DATA_W] = shadow[base + 10'(k)];
            end
        end
        return e;
    endfunction

    task automatic check_word(input string name, input logic [`DATA_W-1:0] exp_val,
            input logic [`DATA_W-1:0] act);
        checks++;
        if (act !== exp_val) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, exp_val, act);
        end
    endtask

    task automatic check_block(input string name, input logic [`BLOCK_W-1:0] exp_val,
            input logic [`BLOCK_W-1:0] act);
        checks++;
        if (act !== exp_val) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, exp_val, act);
        end
    endtask

    task automatic check_resp(input string name, input resp_t exp_val, input resp_t act);
        checks++;
        if (act !== exp_val) begin
            errors++;
            $display("** Error %s: expected %s, actual %s", name, exp_val.name(), act.name());
        end
    endtask

    // each response is matched against the oldest outstanding expectation
    always @(negedge clk) begin
        expect_t e;
        if (response != RESP_NONE) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("response %s arrived with no request outstanding", response.name());
            end else begin
                e = exp_q.pop_front();
                check_resp(e.name, e.resp, response);
                if (e.kind == 1) begin
                    check_word(e.name, e.word, rword_to_cache);
                end else if (e.kind == 2) begin
                    check_block(e.name, e.blk, rblock_to_cache);
                end
            end
        end
    end

    // dcache is predicted first to match the arbitration order
    task automatic serve(input string name, input icache_req_t ireq,
            input logic [`ADDR_W-1:0] iaddr, input dcache_req_t dreq,
            input logic [`ADDR_W-1:0] daddr, input logic [`BLOCK_W-1:0] wblock,
            input logic [`DATA_W-1:0] wword, input logic [`STRB_W-1:0] wstrb);
        expect_t e;
        if (dreq != DREQ_NONE) begin
            e = predict(1'b1, ireq, dreq, daddr, wblock, wword, wstrb);
            e.name = name;
            exp_q.push_back(e);
        end
        if (ireq != IREQ_NONE) begin
            e = predict(1'b0, ireq, dreq, iaddr, wblock, wword, wstrb);
            e.name = name;
            exp_q.push_back(e);
        end
        @(negedge clk);
        icache_req    = ireq;
        icache_addr   = iaddr;
        dcache_req    = dreq;
        dcache_addr   = daddr;
        dcache_wblock = wblock;
        dcache_wword  = wword;
        dcache_wstrb  = wstrb;
        while (icache_req != IREQ_NONE || dcache_req != DREQ_NONE) begin
            @(negedge clk);
            if (response == RESP_DCACHE) begin
                dcache_req = DREQ_NONE;
            end
            if (response == RESP_ICACHE) begin
                icache_req = IREQ_NONE;
            end
        end
    endtask

    task automatic check_wb_beats(input string name, input logic [`ADDR_W-1:0] blk_addr);
        logic [`ADDR_W:0] exp_beat;
        if (beat_log.size() != 2 * `WORDS_PER_BLOCK) begin
            errors++;
            $display("%s: saw %0d memory beats instead of 8", name, beat_log.size());
        end else begin
            for (int i = 0; i < 2 * `WORDS_PER_BLOCK; i++) begin
                exp_beat = {(i < 4), blk_addr + `ADDR_W'((i % 4) * 4)};
                checks++;
                if (beat_log[i] !== exp_beat) begin
                    errors++;
                    $display("** Error %s beat %0d: expected %h, actual %h",
                             name, i, exp_beat, beat_log[i]);
                end
            end
        end
    endtask

    initial begin
        icache_req_t         ireq;
        dcache_req_t         dreq;
        logic [`BLOCK_W-1:0] blk;
        void'($urandom(32'h3c22b664));
        rstn          = 1'b0;
        icache_req    = IREQ_NONE;
        icache_addr   = '0;
        dcache_req    = DREQ_NONE;
        dcache_addr   = '0;
        dcache_wblock = '0;
        dcache_wword  = '0;
        dcache_wstrb  = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[10'(i)]    = 32'(i + 1) * 32'h9e3779b9 ^ 32'h00005a5a;
            shadow[10'(i)] = mem[10'(i)];
        end
        repeat (16) @(negedge clk);
        rstn = 1'b1;

        // quiet bus while nothing is requested
        repeat (20) begin
            @(negedge clk);
            check_resp("idle", RESP_NONE, response);
            if (mem_valid !== 1'b0) begin
                errors++;
                $display("mem_valid went high after reset with no request held");
            end
        end

        serve("icache_block", IREQ_BLOCK, 32'h2c8, DREQ_NONE, '0, '0, '0, '0);
        serve("icache_word", IREQ_WORD, 32'h31c, DREQ_NONE, '0, '0, '0, '0);
        serve("store_partial", IREQ_NONE, '0, DREQ_STORE_WORD, 32'h100, '0,
              32'hdeadbeef, 4'b0101);
        serve("load_merged", IREQ_NONE, '0, DREQ_LOAD_WORD, 32'h100, '0, '0, '0);

        blk = 128'h0badf00d_cafe1234_5566aa77_13572468;
        beat_log.delete();
        serve("wb_refill", IREQ_NONE, '0, DREQ_WB_LOAD_BLOCK, 32'ha34, blk, '0, '0);
        check_wb_beats("wb_refill", 32'ha30);

        serve("both_caches", IREQ_BLOCK, 32'h400, DREQ_LOAD_WORD, 32'h404, '0, '0, '0);

        for (int n = 0; n < 80; n++) begin
            ireq = icache_req_t'($urandom % 3);
            dreq = dcache_req_t'($urandom % 5);
            if (ireq == IREQ_NONE && dreq == DREQ_NONE) begin
                dreq = DREQ_LOAD_WORD;
            end
            serve($sformatf("random_%0d", n), ireq, $urandom % 4096, dreq, $urandom % 4096,
                  {$urandom, $urandom, $urandom, $urandom}, $urandom, 4'($urandom % 16));
        end

        repeat (10) @(negedge clk);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected responses never arrived", exp_q.size());
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+rtl
rtl/cache_bus_pkg.sv
rtl/xfer_if.sv
rtl/cache_req_sequencer.sv
rtl/mem_xfer_engine.sv
rtl/cache_bus_top.sv
tb/tb_cache_bus.sv

// File: Makefile
VERILATOR  ?= verilator
VFLAGS     := --binary --timing --timescale 1ns/100ps -j 0
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/100ps
TOP        := tb_cache_bus
RTL_TOP    := cache_bus_top
FILELIST   := sim.f
OBJ_DIR    := obj_dir
PASS_MSG   := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
